// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := tb_memory_game
RTL_TOP    := memory_game
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: game_phase_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module game_phase_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              all_found,
    output game_pkg::phase_t  phase
);
    import game_pkg::*;

    logic   start_q;
    logic   start_edge;
    phase_t next_phase;

    // Held high so a button down through reset is not taken as an edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q <= 1'b1;
        end else begin
            start_q <= start;
        end
    end

    assign start_edge = start && !start_q;

    always_comb begin
        next_phase = phase;
        unique case (phase)
            PH_IDLE:    if (start_edge) next_phase = PH_PREVIEW;
            PH_PREVIEW: if (start_edge) next_phase = PH_PLAY;
            PH_PLAY:    if (all_found)  next_phase = PH_DONE;
            PH_DONE:    if (start_edge) next_phase = PH_IDLE;
            default:    next_phase = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= PH_IDLE;
        end else begin
            phase <= next_phase;
        end
    end

    // Only the board can end play
    assert property (@(posedge clk) disable iff (rst)
        (phase == PH_PLAY) && !all_found |=> (phase == PH_PLAY));

    assert property (@(posedge clk) disable iff (rst)
        all_found |-> (phase == PH_PLAY));

endmodule

`default_nettype wire

// File: game_pkg.sv
`default_nettype none

package game_pkg;

    localparam int N_TILES = 16;
    localparam int N_PAIRS = 8;

    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_PREVIEW = 2'd1,
        PH_PLAY    = 2'd2,
        PH_DONE    = 2'd3
    } phase_t;

    // Tile n holds image n[2:0]; the msb tells the two copies apart
    typedef struct packed {
        logic       copy;
        logic [2:0] image;
    } tile_pair_t;

    typedef union packed {
        logic [3:0] flat;
        tile_pair_t pair;
    } tile_idx_u;

    typedef logic [3:0] pair_cnt_t;

    // Two distinct tiles showing the same picture
    function automatic logic tiles_pair(tile_idx_u a, tile_idx_u b);
        return (a.pair.image == b.pair.image) && (a.pair.copy != b.pair.copy);
    endfunction

endpackage

`default_nettype wire

// File: key_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module key_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 key_event,
    input  logic                 key_break,
    input  keymap_pkg::scan_code_t key_code,
    output logic                 press,
    output keymap_pkg::key_num_t press_key,
    output keymap_pkg::key_num_t other_key
);
    import keymap_pkg::*;

    key_num_t          code_key;
    logic              code_valid;
    logic              make_new;
    logic              break_held;
    logic [N_KEYS-1:0] held;

    // Two most recent presses still held, newest first
    key_num_t last_key;
    key_num_t prev_key;

    always_comb begin
        code_key = KEY_NONE;
        for (int i = 0; i < $size(SCAN_TILE); i++) begin
            if (key_code == SCAN_TILE[i]) begin
                code_key = key_num_t'(i);
            end
        end
        if (key_code == SCAN_SHIFT) begin
            code_key = KEY_SHIFT;
        end else if (key_code == SCAN_ENTER) begin
            code_key = KEY_ENTER;
        end
    end

    assign code_valid = (code_key != KEY_NONE);

    // Typematic repeats of a key already down do not count as presses
    assign make_new   = key_event && !key_break && code_valid && !held[code_key];
    assign break_held = key_event && key_break && code_valid && held[code_key];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held     <= '0;
            last_key <= KEY_NONE;
            prev_key <= KEY_NONE;
            press    <= 1'b0;
        end else begin
            press <= make_new;
            if (make_new) begin
                held[code_key] <= 1'b1;
                last_key       <= code_key;
                prev_key       <= last_key;
            end else if (break_held) begin
                held[code_key] <= 1'b0;
                if (last_key == code_key) begin
                    last_key <= prev_key;
                    prev_key <= KEY_NONE;
                end else if (prev_key == code_key) begin
                    prev_key <= KEY_NONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (make_new) begin
            press_key <= code_key;
            other_key <= last_key;
        end
    end

    // Companion is never the pressed key itself, and the pressed key is down
    assert property (@(posedge clk) disable iff (rst)
        press |-> (press_key != KEY_NONE) && (press_key != other_key) && held[press_key]);

endmodule

`default_nettype wire

// File: keymap_pkg.sv
`default_nettype none

package keymap_pkg;

    localparam int N_KEYS = 18;

    // Extended-code flag sits in bit 8
    typedef logic [8:0] scan_code_t;
    typedef logic [4:0] key_num_t;

    localparam key_num_t KEY_SHIFT = 5'd16;
    localparam key_num_t KEY_ENTER = 5'd17;
    localparam key_num_t KEY_NONE  = 5'd31;

    localparam scan_code_t SCAN_SHIFT = 9'h012;
    localparam scan_code_t SCAN_ENTER = 9'h05A;

    // Rows 1234 / QWER / ASDF / ZXCV in tile order
    localparam scan_code_t SCAN_TILE [16] = '{
        9'h016, 9'h01E, 9'h026, 9'h025,
        9'h015, 9'h01D, 9'h024, 9'h02D,
        9'h01C, 9'h01B, 9'h023, 9'h02B,
        9'h01A, 9'h022, 9'h021, 9'h02A
    };

endpackage

`default_nettype wire

// File: memory_game.sv
`timescale 1ns/10ps
`default_nettype none

module memory_game #(
    parameter logic [game_pkg::N_TILES-1:0] INIT_FLIP_MASK = 16'h6003
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          hint,
    input  logic                          key_event,
    input  logic                          key_break,
    input  keymap_pkg::scan_code_t        key_code,
    output game_pkg::phase_t              phase,
    output logic                          pass,
    output logic                          move_ready,
    output logic [game_pkg::N_TILES-1:0]  tile_visible,
    output logic [game_pkg::N_TILES-1:0]  tile_flip
);
    import keymap_pkg::*;

    logic     press;
    key_num_t press_key;
    key_num_t other_key;
    logic     all_found;

    key_tracker u_key_tracker (
        .clk       (clk),
        .rst       (rst),
        .key_event (key_event),
        .key_break (key_break),
        .key_code  (key_code),
        .press     (press),
        .press_key (press_key),
        .other_key (other_key)
    );

    game_phase_fsm u_game_phase_fsm (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .all_found (all_found),
        .phase     (phase)
    );

    tile_board #(
        .INIT_FLIP_MASK (INIT_FLIP_MASK)
    ) u_tile_board (
        .clk          (clk),
        .rst          (rst),
        .hint         (hint),
        .press        (press),
        .press_key    (press_key),
        .other_key    (other_key),
        .phase        (phase),
        .tile_visible (tile_visible),
        .tile_flip    (tile_flip),
        .move_ready   (move_ready),
        .pass         (pass),
        .all_found    (all_found)
    );

endmodule

`default_nettype wire

// File: memory_game_testdata.txt
# S phase | W phase | H level | P scan | R scan | M scan scan | E | I cycles
# C phase pass move_ready visible flip, all operands hex
C 0 0 1 0000 0000
S 1
C 1 0 1 ffff 6003
S 2
C 2 0 1 0000 6003
# Matching pair, then a mismatch
M 26 23
C 2 0 0 0404 6003
E
C 2 0 1 0404 6003
M 25 15
C 2 0 0 041c 6003
E
C 2 0 1 0404 6003
# Tile 0 starts flipped
M 16 1c
C 2 0 0 0505 6003
E
P 12
P 16
R 16
R 12
C 2 0 0 0405 6002
E
M 16 1c
E
C 2 0 1 0505 6002
H 1
M 25 2b
C 2 0 1 ffff 0000
H 0
C 2 0 1 0505 6002
M 12 1e
E
M 1e 1b
E
M 25 2b
E
M 15 1a
E
M 12 22
E
M 1d 22
E
M 12 21
E
M 24 21
E
M 2d 2a
E
W 3
I 2
C 3 1 1 ffff 0000
S 0
C 0 0 1 0000 0000

// File: sim.f
game_pkg.sv
keymap_pkg.sv
key_tracker.sv
game_phase_fsm.sv
tile_board.sv
memory_game.sv
tb_memory_game.sv

// File: tb_memory_game.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memory_game;

    localparam int PHASE_TIMEOUT = 32;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   hint;
    logic                   key_event;
    logic                   key_break;
    logic [8:0]             key_code;
    game_pkg::phase_t       phase;
    logic                   pass;
    logic                   move_ready;
    logic [15:0]            tile_visible;
    logic [15:0]            tile_flip;
    integer                 seed;
    int                     fd;

    memory_game #(
        .INIT_FLIP_MASK (16'h6003)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .hint         (hint),
        .key_event    (key_event),
        .key_break    (key_break),
        .key_code     (key_code),
        .phase        (phase),
        .pass         (pass),
        .move_ready   (move_ready),
        .tile_visible (tile_visible),
        .tile_flip    (tile_flip)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("error at %0d ns: %s is %0h, expected %0h",
                               $time, what, got, want));
        end
    endtask

    task automatic wait_phase(input logic [1:0] want);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (phase !== want) begin
            if (cycles == PHASE_TIMEOUT) begin
                fail_run($sformatf("timed out waiting for phase %0d", want));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // One make or break event, then the board settles and a random gap
    task automatic send_key(input logic brk, input logic [8:0] code);
        int gap;
        @(posedge clk);
        key_event <= 1'b1;
        key_break <= brk;
        key_code  <= code;
        @(posedge clk);
        key_event <= 1'b0;
        key_break <= 1'b0;
        @(posedge clk);
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic two_keys(input logic [8:0] first, input logic [8:0] second);
        send_key(1'b0, first);
        send_key(1'b0, second);
        send_key(1'b1, first);
        send_key(1'b1, second);
    endtask

    task automatic start_press(input logic [1:0] want);
        @(posedge clk);
        start <= 1'b1;
        wait_phase(want);
        @(posedge clk);
        start <= 1'b0;
        // Board picks up the new phase one edge later
        repeat (2) @(posedge clk);
    endtask

    task automatic run_script(input int fd);
        logic [7:0]       cmd;
        logic [8*256-1:0] line;
        logic [31:0]      a, b, c, d, e;
        int               n;
        while ($fscanf(fd, " %s", cmd) == 1) begin
            if (cmd == "#") begin
                n = $fgets(line, fd);
            end else if (cmd == "E") begin
                send_key(1'b0, 9'h05a);
                send_key(1'b1, 9'h05a);
            end else if (cmd == "M") begin
                n = $fscanf(fd, " %h %h", a, b);
                two_keys(a[8:0], b[8:0]);
            end else if (cmd == "C") begin
                n = $fscanf(fd, " %h %h %h %h %h", a, b, c, d, e);
                @(negedge clk);
                check_value("phase", 32'(phase), a);
                check_value("pass", 32'(pass), b);
                check_value("move_ready", 32'(move_ready), c);
                check_value("tile_visible", 32'(tile_visible), d);
                check_value("tile_flip", 32'(tile_flip), e);
            end else begin
                n = $fscanf(fd, " %h", a);
                case (cmd)
                    "S": start_press(a[1:0]);
                    "W": wait_phase(a[1:0]);
                    "P": send_key(1'b0, a[8:0]);
                    "R": send_key(1'b1, a[8:0]);
                    "I": repeat (a) @(posedge clk);
                    "H": begin
                        @(posedge clk);
                        hint <= a[0];
                        @(posedge clk);
                    end
                    default: fail_run("unknown command in the testdata file");
                endcase
            end
        end
    endtask

    initial begin
        seed      = 32'hbf52aa6c;
        rst       = 1'b1;
        start     = 1'b0;
        hint      = 1'b0;
        key_event = 1'b0;
        key_break = 1'b0;
        key_code  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("memory_game_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("could not open memory_game_testdata.txt");
        end else begin
            run_script(fd);
            $fclose(fd);
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tile_board.sv
`timescale 1ns/10ps
`default_nettype none

module tile_board #(
    parameter logic [game_pkg::N_TILES-1:0] INIT_FLIP_MASK = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           hint,
    input  logic                           press,
    input  keymap_pkg::key_num_t           press_key,
    input  keymap_pkg::key_num_t           other_key,
    input  game_pkg::phase_t               phase,
    output logic [game_pkg::N_TILES-1:0]   tile_visible,
    output logic [game_pkg::N_TILES-1:0]   tile_flip,
    output logic                           move_ready,
    output logic                           pass,
    output logic                           all_found
);
    import game_pkg::*;
    import keymap_pkg::*;

    logic [N_TILES-1:0] shown;
    logic [N_TILES-1:0] found;
    logic [N_TILES-1:0] flip;
    pair_cnt_t          pair_cnt;
    phase_t             phase_q;

    tile_idx_u tile_a;
    tile_idx_u tile_b;
    tile_idx_u flip_tile;
    logic      hint_play;
    logic      move_en;
    logic      press_tile;
    logic      other_tile;
    logic      shift_combo;
    logic      do_enter;
    logic      do_flip;
    logic      do_pair;
    logic      pair_hit;

    always_comb begin
        tile_a.flat = press_key[3:0];
        tile_b.flat = other_key[3:0];
    end

    assign hint_play = hint && (phase == PH_PLAY);

    // No moves in the cycle play is entered
    assign move_en = press && !hint && (phase == PH_PLAY) && (phase_q == PH_PLAY);

    assign press_tile = press_key < key_num_t'(N_TILES);
    assign other_tile = other_key < key_num_t'(N_TILES);

    assign shift_combo = (press_tile && other_key == KEY_SHIFT) ||
                         (other_tile && press_key == KEY_SHIFT);
    assign flip_tile   = press_tile ? tile_a : tile_b;

    assign do_enter = move_en && (press_key == KEY_ENTER) && !move_ready;
    assign do_flip  = move_en && move_ready && shift_combo && !found[flip_tile.flat];
    assign do_pair  = move_en && move_ready && press_tile && other_tile &&
                      !found[tile_a.flat] && !found[tile_b.flat];

    // Flipped tiles never match, even with the same picture
    assign pair_hit = tiles_pair(tile_a, tile_b) &&
                      !flip[tile_a.flat] && !flip[tile_b.flat];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown      <= '0;
            found      <= '0;
            flip       <= '0;
            pair_cnt   <= '0;
            phase_q    <= PH_IDLE;
            move_ready <= 1'b1;
            pass       <= 1'b0;
            all_found  <= 1'b0;
        end else begin
            phase_q   <= phase;
            all_found <= 1'b0;
            if (phase != phase_q) begin
                move_ready <= 1'b1;
                unique case (phase)
                    PH_IDLE: begin
                        shown    <= '0;
                        found    <= '0;
                        flip     <= '0;
                        pair_cnt <= '0;
                        pass     <= 1'b0;
                    end
                    PH_PREVIEW: begin
                        shown    <= '1;
                        found    <= '0;
                        flip     <= INIT_FLIP_MASK;
                        pair_cnt <= '0;
                        pass     <= 1'b0;
                    end
                    PH_PLAY: begin
                        shown <= '0;
                    end
                    PH_DONE: begin
                        shown    <= '1;
                        found    <= '1;
                        pair_cnt <= pair_cnt_t'(N_PAIRS);
                        pass     <= 1'b1;
                    end
                    default: begin
                        shown <= '0;
                    end
                endcase
            end else if (do_enter) begin
                shown      <= '0;
                move_ready <= 1'b1;
                if (pair_cnt == pair_cnt_t'(N_PAIRS)) begin
                    all_found <= 1'b1;
                end
            end else if (do_flip) begin
                shown[flip_tile.flat] <= 1'b1;
                flip[flip_tile.flat]  <= !flip[flip_tile.flat];
                move_ready            <= 1'b0;
            end else if (do_pair) begin
                shown[tile_a.flat] <= 1'b1;
                shown[tile_b.flat] <= 1'b1;
                move_ready         <= 1'b0;
                if (pair_hit) begin
                    found[tile_a.flat] <= 1'b1;
                    found[tile_b.flat] <= 1'b1;
                    pair_cnt           <= pair_cnt + 1'b1;
                end
            end
        end
    end

    assign tile_visible = hint_play ? '1 : (shown | found);
    assign tile_flip    = hint_play ? '0 : flip;

    // Counter stays in step with the found mask
    assert property (@(posedge clk) disable iff (rst)
        (pair_cnt <= pair_cnt_t'(N_PAIRS)) && ($countones(found) == 2 * pair_cnt));

endmodule

`default_nettype wire
